/* design/dm9000aRxPkg.sv */
package dm9000aRxPkg;

    typedef logic [15:0] wordT;   // one bus word
    typedef logic [10:0] delayT;  // microseconds

    // DM9000A register indexes and cycle select
    localparam wordT regMrcmdx = 16'h00f0;  // memory read, no address increment
    localparam wordT regMrcmd  = 16'h00f2;  // memory read, address increment
    localparam logic ioAddr = 1'b0;         // cmd pin low, index cycle
    localparam logic ioData = 1'b1;         // cmd pin high, data cycle

    localparam logic [7:0] readyMask  = 8'h03;  // only bits 1:0 matter
    localparam logic [7:0] pktReady   = 8'h01;
    localparam logic [7:0] pktUnready = 8'h00;

    localparam wordT statusErrMask = 16'hbf00;  // rx status error flags
    localparam wordT pktMaxSize    = 16'd1024;  // fits the 1 KB frame RAM

    // byte offsets of captured words, counted from the first destination MAC byte
    localparam logic [10:0] offSrcMac0    = 11'd6;
    localparam logic [10:0] offSrcMac1    = 11'd8;
    localparam logic [10:0] offSrcMac2    = 11'd10;
    localparam logic [10:0] offEtherType  = 11'd12;
    localparam logic [10:0] offVerLen     = 11'd14;
    localparam logic [10:0] offIpTotalLen = 11'd16;
    localparam logic [10:0] offFragOp     = 11'd20;  // frag word (IP) or opcode (ARP)
    localparam logic [10:0] offIpProto    = 11'd22;  // proto in low byte
    localparam logic [10:0] offW26        = 11'd26;
    localparam logic [10:0] offW28        = 11'd28;
    localparam logic [10:0] offW30        = 11'd30;
    localparam logic [10:0] offW32        = 11'd32;
    localparam logic [10:0] offIcmpType   = 11'd34;
    localparam logic [10:0] offW38        = 11'd38;
    localparam logic [10:0] offW40        = 11'd40;

    localparam wordT etherArp        = 16'h0806;
    localparam wordT etherIp         = 16'h0800;
    localparam wordT arpOpRequest    = 16'd1;
    localparam logic [7:0] ipProtoIcmp   = 8'd1;
    localparam wordT icmpEchoRequest = 16'h0800;  // type 8, code 0
    localparam logic [7:0] ipv4NoOptions = 8'h45;  // v4, 20 byte header
    localparam wordT fragMask        = 16'h3fff;  // MF flag and offset
    localparam wordT ipHeaderLen     = 16'd20;

    typedef enum logic [4:0] {
        idle, dummyRead, readReady, checkReady, setMrcmd,
        delayStatus, getStatus, delayLength, getLength, checkPkt,
        storeLoop, delayStore, readStore, lowByte, highByte, done,
        drainLoop, delayDrain, readDrain, error, rxReset
    } rxStateT;

endpackage

/* design/rxWordIf.sv */
`timescale 1ns/1ps
interface rxWordIf;
    import dm9000aRxPkg::*;

    logic wordStb;           // one cycle per stored word
    wordT wordData;          // network order
    logic [10:0] wordOffset; // byte offset in frame
    logic frameEnd;          // good frame finished

    modport source (
        output wordStb,
        output wordData,
        output wordOffset,
        output frameEnd
    );

    modport sink (
        input wordStb,
        input wordData,
        input wordOffset,
        input frameEnd
    );
endinterface

/* design/rxSequencer.sv */
`timescale 1ns/1ps
module rxSequencer #(
    parameter dm9000aRxPkg::delayT usDelayTime = 11'd2,
    parameter int ramAddrWidth = 10
) (
    input  logic iDm9000aClk,
    input  logic iRunStart,
    input  logic iorEnd,
    input  logic iordEnd,
    input  logic iowrEnd,
    input  logic usDelayEnd,
    input  logic rxResetEnd,
    input  dm9000aRxPkg::wordT iorValue,
    input  dm9000aRxPkg::wordT iordValue,
    output logic iorStart,
    output dm9000aRxPkg::wordT iorReg,
    output logic iordStart,
    output logic iordIndexOrData,
    output logic iowrStart,
    output logic iowrIndexOrData,
    output dm9000aRxPkg::wordT iowrData,
    output logic usDelayStart,
    output dm9000aRxPkg::delayT usDelayLen,
    output logic rxResetStart,
    output logic ramWren,
    output logic [7:0] ramData,
    output logic [ramAddrWidth-1:0] ramAddr,
    output logic rxDone,
    output logic rxError,
    rxWordIf.source word
);
    import dm9000aRxPkg::*;

    rxStateT state;
    logic [10:0] cnt;      // bytes read, store or drain path
    logic [7:0] rxReady;
    wordT rxStatus;
    wordT rxLength;
    wordT wordBuf;         // last word, bytes swapped
    logic pktGood;

    assign pktGood = ((rxStatus & statusErrMask) == 16'h0000) && (rxLength < pktMaxSize);

    always_ff @(posedge iDm9000aClk or negedge iRunStart) begin
        if (!iRunStart) begin
            state <= idle;
            cnt <= '0;
            ramAddr <= '0;  // frame lands at address 0
            rxDone <= 1'b0;
            rxError <= 1'b0;
        end else begin
            case (state)
                idle:        state <= dummyRead;
                dummyRead:   if (iorEnd) state <= readReady;
                readReady:   if (iordEnd) state <= checkReady;
                checkReady: begin
                    if (rxReady == pktReady)
                        state <= setMrcmd;
                    else if (rxReady == pktUnready)
                        state <= error;  // nothing waiting
                    else
                        state <= rxReset;  // controller out of sync
                end
                setMrcmd:    if (iowrEnd) state <= delayStatus;
                delayStatus: if (usDelayEnd) state <= getStatus;
                getStatus:   if (iordEnd) state <= delayLength;
                delayLength: if (usDelayEnd) state <= getLength;
                getLength:   if (iordEnd) state <= checkPkt;
                checkPkt:    state <= pktGood ? storeLoop : drainLoop;
                storeLoop:   state <= ({5'd0, cnt} < rxLength) ? delayStore : done;
                delayStore:  if (usDelayEnd) state <= readStore;
                readStore: begin
                    if (iordEnd) begin
                        cnt <= cnt + 11'd2;
                        state <= lowByte;
                    end
                end
                lowByte: begin
                    ramAddr <= ramAddr + ramAddrWidth'(1);
                    state <= highByte;
                end
                highByte: begin
                    ramAddr <= ramAddr + ramAddrWidth'(1);
                    state <= storeLoop;
                end
                done:        rxDone <= 1'b1;  // parked until reset
                drainLoop:   state <= ({5'd0, cnt} < rxLength) ? delayDrain : error;
                delayDrain:  if (usDelayEnd) state <= readDrain;
                readDrain: begin
                    if (iordEnd) begin
                        cnt <= cnt + 11'd2;  // word read and dropped
                        state <= drainLoop;
                    end
                end
                error:       rxError <= 1'b1;  // parked until reset
                rxReset:     if (rxResetEnd) state <= error;
                default:     state <= idle;
            endcase
        end
    end

    // captured values, each loaded before it is read
    always_ff @(posedge iDm9000aClk) begin
        case (state)
            dummyRead: if (iorEnd) rxReady <= iorValue[7:0];  // stale, overwritten next
            readReady: if (iordEnd) rxReady <= iordValue[7:0] & readyMask;
            getStatus: if (iordEnd) rxStatus <= iordValue;
            getLength: if (iordEnd) rxLength <= iordValue;
            readStore: begin
                if (iordEnd) begin
                    wordBuf <= {iordValue[7:0], iordValue[15:8]};
                    ramData <= iordValue[7:0];  // first frame byte of the word
                end
            end
            lowByte: ramData <= wordBuf[7:0];  // second byte
            default: ;
        endcase
    end

    // step starts decoded from state, held until the end strobe
    assign iorStart = (state == dummyRead);
    assign iorReg = iorStart ? regMrcmdx : '0;
    assign iordStart = state inside {readReady, getStatus, getLength, readStore, readDrain};
    assign iordIndexOrData = iordStart ? ioData : 1'b0;
    assign iowrStart = (state == setMrcmd);
    assign iowrIndexOrData = ioAddr;  // index write selects MRCMD
    assign iowrData = iowrStart ? regMrcmd : '0;
    assign usDelayStart = state inside {delayStatus, delayLength, delayStore, delayDrain};
    assign usDelayLen = usDelayStart ? usDelayTime : '0;
    assign rxResetStart = (state == rxReset);
    assign ramWren = state inside {lowByte, highByte};

    assign word.wordStb = (state == lowByte);  // cycle after the read returns
    assign word.wordData = wordBuf;
    assign word.wordOffset = cnt - 11'd2;  // cnt already advanced
    assign word.frameEnd = (state == done) && !rxDone;  // first done cycle
endmodule

/* design/headerCapture.sv */
`timescale 1ns/1ps
module headerCapture (
    input  logic iDm9000aClk,
    input  logic iRunStart,
    rxWordIf.sink word,
    output logic [47:0] srcMac,
    output dm9000aRxPkg::wordT etherType,
    output dm9000aRxPkg::wordT verLen,
    output dm9000aRxPkg::wordT ipTotalLen,
    output dm9000aRxPkg::wordT fragOp,
    output logic [7:0] ipProto,
    output dm9000aRxPkg::wordT w26,
    output dm9000aRxPkg::wordT w28,
    output dm9000aRxPkg::wordT w30,
    output dm9000aRxPkg::wordT w32,
    output dm9000aRxPkg::wordT icmpType,
    output dm9000aRxPkg::wordT w38,
    output dm9000aRxPkg::wordT w40
);
    import dm9000aRxPkg::*;

    always_ff @(posedge iDm9000aClk or negedge iRunStart) begin
        if (!iRunStart) begin
            srcMac <= '0;
            etherType <= '0;
            verLen <= '0;
            ipTotalLen <= '0;
            fragOp <= '0;
            ipProto <= '0;
            w26 <= '0;
            w28 <= '0;
            w30 <= '0;
            w32 <= '0;
            icmpType <= '0;
            w38 <= '0;
            w40 <= '0;
        end else if (word.wordStb) begin
            case (word.wordOffset)
                offSrcMac0:    srcMac[47:32] <= word.wordData;
                offSrcMac1:    srcMac[31:16] <= word.wordData;
                offSrcMac2:    srcMac[15:0] <= word.wordData;
                offEtherType:  etherType <= word.wordData;
                offVerLen:     verLen <= word.wordData;  // version, IHL, TOS
                offIpTotalLen: ipTotalLen <= word.wordData;
                offFragOp:     fragOp <= word.wordData;
                offIpProto:    ipProto <= word.wordData[7:0];  // TTL in high byte
                offW26:        w26 <= word.wordData;  // IP src hi, ARP sender MAC
                offW28:        w28 <= word.wordData;
                offW30:        w30 <= word.wordData;
                offW32:        w32 <= word.wordData;
                offIcmpType:   icmpType <= word.wordData;  // type and code
                offW38:        w38 <= word.wordData;  // ping id, ARP target IP hi
                offW40:        w40 <= word.wordData;  // ping seq, ARP target IP lo
                default: ;  // other words not needed
            endcase
        end
    end
endmodule

/* design/frameClassifier.sv */
`timescale 1ns/1ps
module frameClassifier #(
    parameter logic [31:0] localIp = 32'hc0a8_0002
) (
    input  logic iDm9000aClk,
    input  logic iRunStart,
    rxWordIf.sink word,
    input  dm9000aRxPkg::wordT etherType,
    input  dm9000aRxPkg::wordT verLen,
    input  dm9000aRxPkg::wordT ipTotalLen,
    input  dm9000aRxPkg::wordT fragOp,
    input  logic [7:0] capProto,
    input  dm9000aRxPkg::wordT w26,
    input  dm9000aRxPkg::wordT w28,
    input  dm9000aRxPkg::wordT w30,
    input  dm9000aRxPkg::wordT w32,
    input  dm9000aRxPkg::wordT icmpType,
    input  dm9000aRxPkg::wordT w38,
    input  dm9000aRxPkg::wordT w40,
    output logic arpRequest,
    output logic pingRequest,
    output logic [31:0] ipPc,
    output dm9000aRxPkg::wordT ipTotalLength,
    output logic [7:0] ipProto,
    output dm9000aRxPkg::wordT pingId,
    output dm9000aRxPkg::wordT pingSn,
    output dm9000aRxPkg::wordT pingLen
);
    import dm9000aRxPkg::*;

    logic isArp;
    logic isPing;

    // ARP request asking for our address
    assign isArp = (etherType == etherArp) && (fragOp == arpOpRequest)
                && ({w38, w40} == localIp);

    // unfragmented echo request to us, plain 20 byte header
    assign isPing = (etherType == etherIp) && (verLen[15:8] == ipv4NoOptions)
                 && ((fragOp & fragMask) == 16'h0000) && (capProto == ipProtoIcmp)
                 && (icmpType == icmpEchoRequest) && ({w30, w32} == localIp);

    always_ff @(posedge iDm9000aClk or negedge iRunStart) begin
        if (!iRunStart) begin
            arpRequest <= 1'b0;
            pingRequest <= 1'b0;
            ipPc <= '0;
            ipTotalLength <= '0;
            ipProto <= '0;
            pingId <= '0;
            pingSn <= '0;
            pingLen <= '0;
        end else if (word.frameEnd) begin  // header complete here
            arpRequest <= isArp;
            pingRequest <= isPing;
            if (isArp)
                ipPc <= {w28, w30};  // sender IP
            if (isPing) begin
                ipPc <= {w26, w28};  // source IP
                ipTotalLength <= ipTotalLen;
                ipProto <= ipProtoIcmp;
                pingId <= w38;
                pingSn <= w40;
                pingLen <= ipTotalLen - ipHeaderLen;  // ICMP part
            end
        end
    end
endmodule

/* design/dm9000aRxTop.sv */
`timescale 1ns/1ps
module dm9000aRxTop #(
    parameter logic [31:0] localIp = 32'hc0a8_0002,
    parameter dm9000aRxPkg::delayT usDelayTime = 11'd2,
    parameter int ramAddrWidth = 10
) (
    input  logic iDm9000aClk,
    input  logic iRunStart,
    input  logic iorEnd,
    input  logic iordEnd,
    input  logic iowrEnd,
    input  logic usDelayEnd,
    input  logic rxResetEnd,
    input  dm9000aRxPkg::wordT iorValue,
    input  dm9000aRxPkg::wordT iordValue,
    output logic iorStart,
    output dm9000aRxPkg::wordT iorReg,
    output logic iordStart,
    output logic iordIndexOrData,
    output logic iowrStart,
    output logic iowrIndexOrData,
    output dm9000aRxPkg::wordT iowrData,
    output logic usDelayStart,
    output dm9000aRxPkg::delayT usDelayLen,
    output logic rxResetStart,
    output logic ramWren,
    output logic [7:0] ramData,
    output logic [ramAddrWidth-1:0] ramAddr,
    output logic rxDone,
    output logic rxError,
    output logic [47:0] srcMac,
    output logic arpRequest,
    output logic pingRequest,
    output logic [31:0] ipPc,
    output dm9000aRxPkg::wordT ipTotalLength,
    output logic [7:0] ipProto,
    output dm9000aRxPkg::wordT pingId,
    output dm9000aRxPkg::wordT pingSn,
    output dm9000aRxPkg::wordT pingLen
);
    import dm9000aRxPkg::*;

    wordT etherType, verLen, ipTotalLen, fragOp, icmpType;
    wordT w26, w28, w30, w32, w38, w40;
    logic [7:0] hdrProto;  // protocol byte as captured

    rxWordIf rxWord ();

    rxSequencer #(
        .usDelayTime(usDelayTime),
        .ramAddrWidth(ramAddrWidth)
    ) seq0 (
        .iDm9000aClk, .iRunStart, .iorEnd, .iordEnd, .iowrEnd, .usDelayEnd, .rxResetEnd,
        .iorValue, .iordValue, .iorStart, .iorReg, .iordStart, .iordIndexOrData,
        .iowrStart, .iowrIndexOrData, .iowrData, .usDelayStart, .usDelayLen,
        .rxResetStart, .ramWren, .ramData, .ramAddr, .rxDone, .rxError,
        .word(rxWord.source)
    );

    headerCapture hdr0 (
        .iDm9000aClk, .iRunStart, .word(rxWord.sink), .srcMac, .etherType, .verLen,
        .ipTotalLen, .fragOp, .ipProto(hdrProto), .w26, .w28, .w30, .w32, .icmpType,
        .w38, .w40
    );

    frameClassifier #(
        .localIp(localIp)
    ) cls0 (
        .iDm9000aClk, .iRunStart, .word(rxWord.sink), .etherType, .verLen, .ipTotalLen,
        .fragOp, .capProto(hdrProto), .w26, .w28, .w30, .w32, .icmpType, .w38, .w40,
        .arpRequest, .pingRequest, .ipPc, .ipTotalLength, .ipProto, .pingId, .pingSn,
        .pingLen
    );
endmodule

/* verification/dm9000aRxChecker.sv */
`timescale 1ns/1ps
module dm9000aRxChecker (
    input logic iDm9000aClk,
    input logic iRunStart,
    input logic iorStart,
    input logic iordStart,
    input logic iowrStart,
    input logic usDelayStart,
    input logic rxResetStart,
    input logic iorEnd,
    input logic iordEnd,
    input logic iowrEnd,
    input logic usDelayEnd,
    input logic rxResetEnd,
    input logic ramWren,
    input logic rxDone,
    input logic rxError
);

    assert property (@(posedge iDm9000aClk) disable iff (!iRunStart)
        $onehot0({iorStart, iordStart, iowrStart, usDelayStart, rxResetStart}))
        else $error("more than one bus step start is high");

    // each start is a level held until its end strobe
    assert property (@(posedge iDm9000aClk) disable iff (!iRunStart)
        iorStart && !iorEnd |=> iorStart) else $error("ior start dropped before its end");
    assert property (@(posedge iDm9000aClk) disable iff (!iRunStart)
        iordStart && !iordEnd |=> iordStart) else $error("iord start dropped before its end");
    assert property (@(posedge iDm9000aClk) disable iff (!iRunStart)
        iowrStart && !iowrEnd |=> iowrStart) else $error("iowr start dropped before its end");
    assert property (@(posedge iDm9000aClk) disable iff (!iRunStart)
        usDelayStart && !usDelayEnd |=> usDelayStart) else $error("delay start dropped early");
    assert property (@(posedge iDm9000aClk) disable iff (!iRunStart)
        rxResetStart && !rxResetEnd |=> rxResetStart) else $error("reset start dropped early");

    assert property (@(posedge iDm9000aClk) disable iff (!iRunStart)
        !(rxDone && rxError)) else $error("done and error are high together");

    // byte writes only right after a returned data read, low then high byte
    assert property (@(posedge iDm9000aClk) disable iff (!iRunStart)
        $rose(ramWren) |-> $past(iordStart && iordEnd))
        else $error("RAM write not preceded by a data read");
    assert property (@(posedge iDm9000aClk) disable iff (!iRunStart)
        $rose(ramWren) |=> ramWren)
        else $error("RAM write burst shorter than two cycles");
    assert property (@(posedge iDm9000aClk) disable iff (!iRunStart)
        ramWren && $past(ramWren) |=> !ramWren)
        else $error("RAM write burst longer than two cycles");
endmodule

bind rxSequencer dm9000aRxChecker chk0 (
    .iDm9000aClk(iDm9000aClk), .iRunStart(iRunStart), .iorStart(iorStart),
    .iordStart(iordStart), .iowrStart(iowrStart), .usDelayStart(usDelayStart),
    .rxResetStart(rxResetStart), .iorEnd(iorEnd), .iordEnd(iordEnd), .iowrEnd(iowrEnd),
    .usDelayEnd(usDelayEnd), .rxResetEnd(rxResetEnd), .ramWren(ramWren),
    .rxDone(rxDone), .rxError(rxError)
);

/* verification/dm9000aRxTb.sv */
`timescale 1ns/1ps
module dm9000aRxTb;
    import dm9000aRxPkg::*;

    localparam int numTests = 7;
    localparam int maxFrameWords = 32;
    localparam int clkPeriod = 40;
    localparam logic [31:0] localIp = 32'hc0a8_0002;  // 192.168.0.2

    logic iDm9000aClk = 1'b0;
    logic iRunStart;
    logic iorEnd, iordEnd, iowrEnd, usDelayEnd, rxResetEnd;
    wordT iorValue, iordValue;
    logic iorStart, iordStart, iowrStart, iowrIndexOrData, iordIndexOrData;
    logic usDelayStart, rxResetStart, ramWren, rxDone, rxError;
    wordT iorReg, iowrData;
    delayT usDelayLen;
    logic [7:0] ramData;
    logic [9:0] ramAddr;
    logic [47:0] srcMac;
    logic arpRequest, pingRequest;
    logic [31:0] ipPc;
    wordT ipTotalLength, pingId, pingSn, pingLen;
    logic [7:0] ipProto;

    logic [7:0] frameBytes [0:63];
    int frameLen;
    logic [7:0] ramModel [0:1023];
    wordT scriptQ [$];  // iord return values in order
    int iordCount, iowrCount, ramWriteCount, checkCount, errCount;
    logic resetSeen;
    logic [31:0] lfsrState = 32'hcd5a_0439;

    dm9000aRxTop #(.localIp(localIp), .usDelayTime(11'd2), .ramAddrWidth(10)) dut0 (
        .iDm9000aClk, .iRunStart, .iorEnd, .iordEnd, .iowrEnd, .usDelayEnd, .rxResetEnd,
        .iorValue, .iordValue, .iorStart, .iorReg, .iordStart, .iordIndexOrData,
        .iowrStart, .iowrIndexOrData, .iowrData, .usDelayStart, .usDelayLen,
        .rxResetStart, .ramWren, .ramData, .ramAddr, .rxDone, .rxError, .srcMac,
        .arpRequest, .pingRequest, .ipPc, .ipTotalLength, .ipProto, .pingId, .pingSn,
        .pingLen
    );

    always #(clkPeriod / 2) iDm9000aClk = ~iDm9000aClk;

    function automatic logic takeBit();  // Galois LFSR, one step per bit
        logic lsb;
        lsb = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (lsb)
            lfsrState = lfsrState ^ 32'h8020_0003;
        return lsb;
    endfunction

    // bus-primitive responder, end after 1 to 4 cycles
    always begin
        int delayLeft;
        @(negedge iDm9000aClk);
        if (iorStart || iordStart || iowrStart || usDelayStart || rxResetStart) begin
            delayLeft = 1 + int'({takeBit(), takeBit()});
            repeat (delayLeft - 1) @(negedge iDm9000aClk);
            if (iorStart) begin
                checkThat(iorReg == 16'h00f0, "dummy read not of MRCMDX");
                iorValue = 16'h0000;  // dummy read, ignored
                iorEnd = 1'b1;
            end else if (iordStart) begin
                checkThat(iordIndexOrData == 1'b1, "data read not a data cycle");
                iordValue = (scriptQ.size() > 0) ? scriptQ.pop_front() : 16'h0000;
                iordCount++;
                iordEnd = 1'b1;
            end else if (iowrStart) begin
                checkThat(iowrData == 16'h00f2 && iowrIndexOrData == 1'b0,
                          "MRCMD index write wrong");
                iowrCount++;
                iowrEnd = 1'b1;
            end else if (usDelayStart) begin
                checkThat(usDelayLen == 11'd2, "delay length wrong");
                usDelayEnd = 1'b1;
            end else begin
                resetSeen = 1'b1;
                rxResetEnd = 1'b1;
            end
            @(negedge iDm9000aClk);
            iorEnd = 1'b0;
            iordEnd = 1'b0;
            iowrEnd = 1'b0;
            usDelayEnd = 1'b0;
            rxResetEnd = 1'b0;
        end
    end

    always @(negedge iDm9000aClk) begin  // RAM model
        if (iRunStart && ramWren) begin
            ramModel[ramAddr] = ramData;
            ramWriteCount++;
        end
    end

    initial begin  // watchdog
        #(numTests * (maxFrameWords * 8 + 40) * clkPeriod);
        $display("timeout, the DUT never finished a frame");
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic checkThat(input logic cond, input string msg);
        checkCount++;
        assert (cond) else begin
            errCount++;
            $display("[FAIL] %0t %s", $time, msg);
        end
    endtask

    task automatic putWord(input int off, input wordT w);
        frameBytes[off] = w[15:8];  // network order
        frameBytes[off + 1] = w[7:0];
    endtask

    task automatic buildPing(input logic [31:0] dstIp, input wordT fragWord);
        for (int i = 0; i < 64; i++)
            frameBytes[i] = 8'(i * 13 + 7);
        frameLen = 46;
        putWord(12, etherIp);
        putWord(14, 16'h4500);
        putWord(16, 16'd32);  // total length
        putWord(20, fragWord);
        putWord(22, 16'h4001);  // TTL, ICMP
        putWord(26, 16'hc0a8);
        putWord(28, 16'h000a);
        putWord(30, dstIp[31:16]);
        putWord(32, dstIp[15:0]);
        putWord(34, 16'h0800);  // echo request
        putWord(38, 16'h1234);
        putWord(40, 16'h0007);
    endtask

    task automatic buildArp(input logic [31:0] targetIp);
        for (int i = 0; i < 64; i++)
            frameBytes[i] = 8'(i * 29 + 3);
        frameLen = 42;
        putWord(12, etherArp);
        putWord(14, 16'h0001);
        putWord(16, 16'h0800);
        putWord(18, 16'h0604);
        putWord(20, 16'h0001);  // request
        putWord(28, 16'hc0a8);  // sender IP
        putWord(30, 16'h0065);
        putWord(38, targetIp[31:16]);
        putWord(40, targetIp[15:0]);
    endtask

    // reset, load the script, release, wait for done or error
    task automatic runFrame(input wordT readyWord, input wordT statusWord, input logic withFrame);
        @(negedge iDm9000aClk);
        iRunStart = 1'b0;
        repeat (10) @(negedge iDm9000aClk);
        scriptQ.delete();
        iordCount = 0;
        iowrCount = 0;
        ramWriteCount = 0;
        resetSeen = 1'b0;
        for (int i = 0; i < 1024; i++)
            ramModel[i] = 8'(i ^ (i >> 8) ^ 8'ha5);
        scriptQ.push_back(readyWord);
        if (withFrame) begin
            scriptQ.push_back(statusWord);
            scriptQ.push_back(16'(frameLen));
            for (int i = 0; i < frameLen; i += 2)
                scriptQ.push_back({frameBytes[i + 1], frameBytes[i]});
        end
        iRunStart = 1'b1;
        while (!(rxDone || rxError)) @(negedge iDm9000aClk);
    endtask

    task automatic checkRam();
        for (int i = 0; i < frameLen; i++)
            checkThat(ramModel[i] == frameBytes[i], $sformatf("RAM byte %0d wrong", i));
    endtask

    initial begin
        iRunStart = 1'b0;
        {iorEnd, iordEnd, iowrEnd, usDelayEnd, rxResetEnd} = '0;
        iorValue = '0;
        iordValue = '0;
        checkCount = 0;
        errCount = 0;

        buildPing(localIp, 16'h0000);
        runFrame(16'h0001, 16'h0000, 1'b1);
        checkRam();
        checkThat(rxDone && pingRequest && !arpRequest, "good ping not flagged");
        checkThat(ipPc == 32'hc0a8_000a, "ping source IP wrong");
        checkThat(pingId == 16'h1234 && pingSn == 16'h0007, "ping id or sequence wrong");
        checkThat(pingLen == 16'd12 && ipTotalLength == 16'd32, "ping lengths wrong");
        checkThat(ipProto == 8'd1, "ping protocol not ICMP");
        checkThat(srcMac == {frameBytes[6], frameBytes[7], frameBytes[8], frameBytes[9],
                             frameBytes[10], frameBytes[11]}, "source MAC wrong");

        buildArp(localIp);
        runFrame(16'h0001, 16'h0000, 1'b1);
        checkRam();
        checkThat(rxDone && arpRequest && !pingRequest, "ARP request not flagged");
        checkThat(ipPc == 32'hc0a8_0065, "ARP sender IP wrong");

        buildPing(32'hc0a8_0003, 16'h0000);
        runFrame(16'h0001, 16'h0000, 1'b1);
        checkThat(rxDone && !pingRequest && !arpRequest, "ping to other IP flagged");

        buildPing(localIp, 16'h2000);  // more-fragments bit
        runFrame(16'h0001, 16'h0000, 1'b1);
        checkThat(rxDone && !pingRequest && !arpRequest, "fragmented ping flagged");

        buildPing(localIp, 16'h0000);
        runFrame(16'h0001, 16'h0200, 1'b1);
        checkThat(rxError && !rxDone, "bad status not reported as error");
        checkThat(ramWriteCount == 0, "bad frame written to RAM");
        checkThat(iordCount - 3 == (frameLen + 1) / 2, "drain read count wrong");
        checkThat(!pingRequest && !arpRequest, "request flagged on drain path");

        runFrame(16'h0000, 16'h0000, 1'b0);
        checkThat(rxError && iowrCount == 0, "unready byte handled wrong");

        runFrame(16'h0002, 16'h0000, 1'b0);
        checkThat(rxError && resetSeen, "bad ready byte did not reset the controller");
        checkThat(!pingRequest && !arpRequest, "request flagged on error path");

        $display("checks %0d, errors %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end
endmodule

/* dm9000aRx.f */
design/dm9000aRxPkg.sv
design/rxWordIf.sv
design/rxSequencer.sv
design/headerCapture.sv
design/frameClassifier.sv
design/dm9000aRxTop.sv
verification/dm9000aRxChecker.sv
verification/dm9000aRxTb.sv

/* runSim.sh */
#!/bin/bash
# build with Verilator, run, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module dm9000aRxTb -f dm9000aRx.f -o simv \
    && simOut="$(./obj_dir/simv)" \
    && echo "$simOut" \
    && echo "$simOut" | grep -qx "RESULT: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
